//--- source/csr_pkg.sv
package csr_pkg;

  localparam int CSR_ADDR_W = 14;
  localparam int XLEN = 32;

  // register addresses
  localparam logic [CSR_ADDR_W-1:0] CSR_CRMD   = 14'h000;
  localparam logic [CSR_ADDR_W-1:0] CSR_PRMD   = 14'h001;
  localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT  = 14'h005;
  localparam logic [CSR_ADDR_W-1:0] CSR_ERA    = 14'h006;
  localparam logic [CSR_ADDR_W-1:0] CSR_EENTRY = 14'h00c;
  localparam logic [CSR_ADDR_W-1:0] CSR_SAVE0  = 14'h030;
  localparam logic [CSR_ADDR_W-1:0] CSR_SAVE1  = 14'h031;
  localparam logic [CSR_ADDR_W-1:0] CSR_SAVE2  = 14'h032;
  localparam logic [CSR_ADDR_W-1:0] CSR_SAVE3  = 14'h033;
  localparam logic [CSR_ADDR_W-1:0] CSR_TID    = 14'h040;
  localparam logic [CSR_ADDR_W-1:0] CSR_TCFG   = 14'h041;
  localparam logic [CSR_ADDR_W-1:0] CSR_TVAL   = 14'h042;
  localparam logic [CSR_ADDR_W-1:0] CSR_TICLR  = 14'h044;

  // counter read codes
  localparam logic [1:0] RDCNT_NONE  = 2'd0;
  localparam logic [1:0] RDCNT_ID    = 2'd1;
  localparam logic [1:0] RDCNT_VLOW  = 2'd2;
  localparam logic [1:0] RDCNT_VHIGH = 2'd3;

  localparam logic [XLEN-1:0] CRMD_RESET = 32'h0000_0008;
  // eentry is 64-byte aligned
  localparam int EENTRY_VA_LSB = 6;

  typedef struct packed {
    logic [22:0] rsvd;
    logic [1:0]  datm;
    logic [1:0]  datf;
    logic        pg;
    logic        da;
    logic        ie;
    logic [1:0]  plv;
  } crmd_t;

  typedef struct packed {
    logic [28:0] rsvd;
    logic        pie;
    logic [1:0]  pplv;
  } prmd_t;

  typedef struct packed {
    logic       rsvd31;
    logic [8:0] esubcode;
    logic [5:0] ecode;
    logic [3:0] rsvd15_12;
    logic       ti;
    logic       rsvd10;
    logic [7:0] hwi;
    logic [1:0] swi;
  } estat_t;

  typedef struct packed {
    logic [29:0] initval;
    logic        periodic;
    logic        en;
  } tcfg_t;

  typedef struct packed {
    logic [30:0] rsvd;
    logic        clr;
  } ticlr_t;

  // merged write word, read through the view of the target register
  typedef union packed {
    logic [XLEN-1:0] raw;
    crmd_t           crmd;
    prmd_t           prmd;
    estat_t          estat;
    tcfg_t           tcfg;
    ticlr_t          ticlr;
  } csr_wdata_u;

  typedef struct packed {
    logic       crmd;
    logic       prmd;
    logic       estat;
    logic       era;
    logic       eentry;
    logic [3:0] save;
    logic       tid;
    logic       tcfg;
    logic       tval;
    logic       ticlr;
  } csr_we_t;

  typedef struct packed {
    csr_we_t    we;
    csr_wdata_u data;
  } csr_wr_t;

  typedef struct packed {
    logic            excp;
    logic            ertn;
    logic [5:0]      ecode;
    logic [8:0]      esubcode;
    logic [XLEN-1:0] pc;
  } excp_t;

  typedef struct packed {
    crmd_t           crmd;
    prmd_t           prmd;
    estat_t          estat;
    logic [XLEN-1:0] era;
    logic [XLEN-1:0] eentry;
  } csr_state_t;

  typedef struct packed {
    tcfg_t           tcfg;
    logic [XLEN-1:0] tval;
    logic [63:0]     stable_cnt;
  } timer_state_t;

endpackage

//--- source/csr_write_port.sv
module csr_write_port (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             csr_we_i,
  input  logic                             valid_i,
  input  logic                             commit_i,
  input  logic                             m2_stall_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0]   csr_w_addr_i,
  input  logic [csr_pkg::XLEN-1:0]         csr_w_mask_i,
  input  logic [csr_pkg::XLEN-1:0]         csr_w_data_i,
  input  logic [csr_pkg::XLEN-1:0]         csr_r_data_i,
  output csr_pkg::csr_wr_t                 wr_o
);

  logic wr_en;

  // only a committed, unstalled instruction may write
  assign wr_en = csr_we_i && valid_i && commit_i && !m2_stall_i;

  // masked bits come from the new data, the rest from the old value
  assign wr_o.data.raw = (csr_r_data_i & ~csr_w_mask_i) | (csr_w_data_i & csr_w_mask_i);

  always_comb begin
    wr_o.we = '0;
    if (wr_en) begin
      case (csr_w_addr_i)
        csr_pkg::CSR_CRMD:   wr_o.we.crmd = 1'b1;
        csr_pkg::CSR_PRMD:   wr_o.we.prmd = 1'b1;
        csr_pkg::CSR_ESTAT:  wr_o.we.estat = 1'b1;
        csr_pkg::CSR_ERA:    wr_o.we.era = 1'b1;
        csr_pkg::CSR_EENTRY: wr_o.we.eentry = 1'b1;
        csr_pkg::CSR_SAVE0:  wr_o.we.save[0] = 1'b1;
        csr_pkg::CSR_SAVE1:  wr_o.we.save[1] = 1'b1;
        csr_pkg::CSR_SAVE2:  wr_o.we.save[2] = 1'b1;
        csr_pkg::CSR_SAVE3:  wr_o.we.save[3] = 1'b1;
        csr_pkg::CSR_TID:    wr_o.we.tid = 1'b1;
        csr_pkg::CSR_TCFG:   wr_o.we.tcfg = 1'b1;
        csr_pkg::CSR_TVAL:   wr_o.we.tval = 1'b1;
        csr_pkg::CSR_TICLR:  wr_o.we.ticlr = 1'b1;
        default:             wr_o.we = '0;
      endcase
    end
  end

endmodule

//--- source/csr_trap_regs.sv
module csr_trap_regs (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_pkg::csr_wr_t    wr_i,
  input  csr_pkg::excp_t      excp_i,
  input  logic [7:0]          hw_int_i,
  input  logic                timer_int_i,
  output csr_pkg::csr_state_t state_o
);

  csr_pkg::crmd_t                     crmd_q;
  csr_pkg::prmd_t                     prmd_q;
  logic [1:0]                         swi_q;
  logic [7:0]                         hwi_q;
  logic [5:0]                         ecode_q;
  logic [8:0]                         esubcode_q;
  logic [csr_pkg::XLEN-1:0]           era_q;
  logic [csr_pkg::XLEN-1:csr_pkg::EENTRY_VA_LSB] eentry_q;

  // later assignments win, so a write beats excp and ertn on its own bits
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q     <= csr_pkg::CRMD_RESET;
      prmd_q     <= '0;
      swi_q      <= '0;
      hwi_q      <= '0;
      ecode_q    <= '0;
      esubcode_q <= '0;
      era_q      <= '0;
      eentry_q   <= '0;
    end else begin
      hwi_q <= hw_int_i;
      if (excp_i.excp) begin
        prmd_q.pplv <= crmd_q.plv;
        prmd_q.pie  <= crmd_q.ie;
        crmd_q.plv  <= 2'b00;
        crmd_q.ie   <= 1'b0;
        ecode_q     <= excp_i.ecode;
        esubcode_q  <= excp_i.esubcode;
        era_q       <= excp_i.pc;
      end
      if (excp_i.ertn) begin
        crmd_q.plv <= prmd_q.pplv;
        crmd_q.ie  <= prmd_q.pie;
      end
      if (wr_i.we.crmd) begin
        crmd_q[8:0] <= wr_i.data.crmd[8:0];
      end
      if (wr_i.we.prmd) begin
        prmd_q.pie  <= wr_i.data.prmd.pie;
        prmd_q.pplv <= wr_i.data.prmd.pplv;
      end
      if (wr_i.we.estat) begin
        swi_q <= wr_i.data.estat.swi;
      end
      if (wr_i.we.era) begin
        era_q <= wr_i.data.raw;
      end
      if (wr_i.we.eentry) begin
        eentry_q <= wr_i.data.raw[csr_pkg::XLEN-1:csr_pkg::EENTRY_VA_LSB];
      end
    end
  end

  always_comb begin
    state_o                = '0;
    state_o.crmd           = crmd_q;
    state_o.prmd           = prmd_q;
    state_o.estat.swi      = swi_q;
    state_o.estat.hwi      = hwi_q;
    // timer interrupt is a live level from the timer block
    state_o.estat.ti       = timer_int_i;
    state_o.estat.ecode    = ecode_q;
    state_o.estat.esubcode = esubcode_q;
    state_o.era            = era_q;
    state_o.eentry         = {eentry_q, {csr_pkg::EENTRY_VA_LSB{1'b0}}};
  end

endmodule

//--- source/csr_timer.sv
module csr_timer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  csr_pkg::csr_wr_t      wr_i,
  output csr_pkg::timer_state_t timer_o,
  output logic                  timer_int_o
);

  csr_pkg::tcfg_t           tcfg_q;
  logic [csr_pkg::XLEN-1:0] tval_q;
  logic                     timer_en_q;
  logic                     ti_q;
  logic [63:0]              stable_cnt_q;
  logic                     expire;
  logic                     ti_clr;

  // countdown reaches zero while armed, unless software reloads it now
  assign expire = timer_en_q && (tval_q == '0) && !wr_i.we.tcfg;
  assign ti_clr = wr_i.we.ticlr && wr_i.data.ticlr.clr;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_q     <= '0;
      tval_q     <= '0;
      timer_en_q <= 1'b0;
      ti_q       <= 1'b0;
    end else begin
      if (wr_i.we.tcfg) begin
        tcfg_q     <= wr_i.data.tcfg;
        tval_q     <= {wr_i.data.tcfg.initval, 2'b00};
        timer_en_q <= wr_i.data.tcfg.en;
      end else if (timer_en_q) begin
        if (tval_q != '0) begin
          tval_q <= tval_q - 1'b1;
        end else begin
          // one-shot parks at all ones
          tval_q     <= tcfg_q.periodic ? {tcfg_q.initval, 2'b00} : '1;
          timer_en_q <= tcfg_q.periodic;
        end
      end
      // clear wins over a simultaneous expiry
      if (ti_clr) begin
        ti_q <= 1'b0;
      end else if (expire) begin
        ti_q <= 1'b1;
      end
    end
  end

  // free-running stable counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stable_cnt_q <= '0;
    end else begin
      stable_cnt_q <= stable_cnt_q + 64'd1;
    end
  end

  assign timer_o.tcfg       = tcfg_q;
  assign timer_o.tval       = tval_q;
  assign timer_o.stable_cnt = stable_cnt_q;
  assign timer_int_o        = ti_q;

endmodule

//--- source/csr_save_regs.sv
module csr_save_regs (
  input  logic                           clk,
  input  logic                           rst_n,
  input  csr_pkg::csr_wr_t               wr_i,
  output logic [3:0][csr_pkg::XLEN-1:0]  save_o,
  output logic [csr_pkg::XLEN-1:0]       tid_o
);

  logic [3:0][csr_pkg::XLEN-1:0] save_q;
  logic [csr_pkg::XLEN-1:0]      tid_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      save_q <= '0;
      tid_q  <= '0;
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (wr_i.we.save[i]) begin
          save_q[i] <= wr_i.data.raw;
        end
      end
      if (wr_i.we.tid) begin
        tid_q <= wr_i.data.raw;
      end
    end
  end

  assign save_o = save_q;
  assign tid_o  = tid_q;

endmodule

//--- source/csr_read_mux.sv
module csr_read_mux (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           m2_stall_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_r_addr_i,
  input  logic [1:0]                     rdcnt_i,
  input  csr_pkg::csr_state_t            state_i,
  input  csr_pkg::timer_state_t          timer_i,
  input  logic [3:0][csr_pkg::XLEN-1:0]  save_i,
  input  logic [csr_pkg::XLEN-1:0]       tid_i,
  output logic [csr_pkg::XLEN-1:0]       csr_r_data_o
);

  logic [csr_pkg::XLEN-1:0] rd_sel;

  always_comb begin
    case (rdcnt_i)
      csr_pkg::RDCNT_ID:    rd_sel = tid_i;
      csr_pkg::RDCNT_VLOW:  rd_sel = timer_i.stable_cnt[31:0];
      csr_pkg::RDCNT_VHIGH: rd_sel = timer_i.stable_cnt[63:32];
      default: begin
        // full 14-bit compare, ticlr and unknown addresses read zero
        case (csr_r_addr_i)
          csr_pkg::CSR_CRMD:   rd_sel = state_i.crmd;
          csr_pkg::CSR_PRMD:   rd_sel = state_i.prmd;
          csr_pkg::CSR_ESTAT:  rd_sel = state_i.estat;
          csr_pkg::CSR_ERA:    rd_sel = state_i.era;
          csr_pkg::CSR_EENTRY: rd_sel = state_i.eentry;
          csr_pkg::CSR_SAVE0:  rd_sel = save_i[0];
          csr_pkg::CSR_SAVE1:  rd_sel = save_i[1];
          csr_pkg::CSR_SAVE2:  rd_sel = save_i[2];
          csr_pkg::CSR_SAVE3:  rd_sel = save_i[3];
          csr_pkg::CSR_TID:    rd_sel = tid_i;
          csr_pkg::CSR_TCFG:   rd_sel = timer_i.tcfg;
          csr_pkg::CSR_TVAL:   rd_sel = timer_i.tval;
          default:             rd_sel = '0;
        endcase
      end
    endcase
  end

  // holds during a stall
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      csr_r_data_o <= '0;
    end else if (!m2_stall_i) begin
      csr_r_data_o <= rd_sel;
    end
  end

endmodule

//--- source/csr_top.sv
module csr_top (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           csr_we_i,
  input  logic                           valid_i,
  input  logic                           commit_i,
  input  logic                           m2_stall_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_w_addr_i,
  input  logic [csr_pkg::XLEN-1:0]       csr_w_mask_i,
  input  logic [csr_pkg::XLEN-1:0]       csr_w_data_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_r_addr_i,
  input  logic [1:0]                     rdcnt_i,
  input  csr_pkg::excp_t                 excp_i,
  input  logic [7:0]                     hw_int_i,
  output logic [csr_pkg::XLEN-1:0]       csr_r_data_o,
  output csr_pkg::csr_state_t            csr_state_o
);

  csr_pkg::csr_wr_t              wr;
  csr_pkg::timer_state_t         timer;
  logic                          timer_int;
  logic [3:0][csr_pkg::XLEN-1:0] save;
  logic [csr_pkg::XLEN-1:0]      tid;

  // merge uses the read issued for the same CSR one cycle earlier
  csr_write_port csr_write_port_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_we_i     (csr_we_i),
    .valid_i      (valid_i),
    .commit_i     (commit_i),
    .m2_stall_i   (m2_stall_i),
    .csr_w_addr_i (csr_w_addr_i),
    .csr_w_mask_i (csr_w_mask_i),
    .csr_w_data_i (csr_w_data_i),
    .csr_r_data_i (csr_r_data_o),
    .wr_o         (wr)
  );

  csr_trap_regs csr_trap_regs_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_i        (wr),
    .excp_i      (excp_i),
    .hw_int_i    (hw_int_i),
    .timer_int_i (timer_int),
    .state_o     (csr_state_o)
  );

  csr_timer csr_timer_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .wr_i        (wr),
    .timer_o     (timer),
    .timer_int_o (timer_int)
  );

  csr_save_regs csr_save_regs_i (
    .clk    (clk),
    .rst_n  (rst_n),
    .wr_i   (wr),
    .save_o (save),
    .tid_o  (tid)
  );

  csr_read_mux csr_read_mux_i (
    .clk          (clk),
    .rst_n        (rst_n),
    .m2_stall_i   (m2_stall_i),
    .csr_r_addr_i (csr_r_addr_i),
    .rdcnt_i      (rdcnt_i),
    .state_i      (csr_state_o),
    .timer_i      (timer),
    .save_i       (save),
    .tid_i        (tid),
    .csr_r_data_o (csr_r_data_o)
  );

endmodule

//--- testbench/csr_checker.sv
module csr_checker (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           csr_we_i,
  input  logic                           valid_i,
  input  logic                           commit_i,
  input  logic                           m2_stall_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_w_addr_i,
  input  logic [csr_pkg::XLEN-1:0]       csr_w_mask_i,
  input  logic [csr_pkg::XLEN-1:0]       csr_w_data_i,
  input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_r_addr_i,
  input  logic [1:0]                     rdcnt_i,
  input  csr_pkg::excp_t                 excp_i,
  input  logic [7:0]                     hw_int_i,
  input  logic [csr_pkg::XLEN-1:0]       r_data_i,
  input  csr_pkg::csr_state_t            state_i,
  output int                             err_cnt_o,
  output int                             check_cnt_o
);
  timeunit 1ns;
  timeprecision 1ps;

  logic [31:0] m_crmd;
  logic [31:0] m_prmd;
  logic [31:0] m_era;
  logic [31:0] m_eentry;
  logic [31:0] m_tcfg;
  logic [31:0] m_tval;
  logic [31:0] m_tid;
  logic [31:0] m_rd;
  logic [31:0] m_save [4];
  logic [1:0]  m_swi;
  logic [7:0]  m_hwi;
  logic [5:0]  m_ecode;
  logic [8:0]  m_esub;
  logic        m_ten;
  logic        m_ti;
  logic [63:0] m_cnt;
  logic        model_valid = 1'b0;

  initial begin
    err_cnt_o   = 0;
    check_cnt_o = 0;
  end

  function automatic logic [31:0] estat_word();
    return {1'b0, m_esub, m_ecode, 4'b0000, m_ti, 1'b0, m_hwi, m_swi};
  endfunction

  function automatic logic [31:0] read_model(input logic [13:0] addr, input logic [1:0] sel);
    logic [31:0] v;
    v = '0;
    case (sel)
      csr_pkg::RDCNT_ID:    v = m_tid;
      csr_pkg::RDCNT_VLOW:  v = m_cnt[31:0];
      csr_pkg::RDCNT_VHIGH: v = m_cnt[63:32];
      default: begin
        case (addr)
          csr_pkg::CSR_CRMD:   v = m_crmd;
          csr_pkg::CSR_PRMD:   v = m_prmd;
          csr_pkg::CSR_ESTAT:  v = estat_word();
          csr_pkg::CSR_ERA:    v = m_era;
          csr_pkg::CSR_EENTRY: v = m_eentry;
          csr_pkg::CSR_SAVE0:  v = m_save[0];
          csr_pkg::CSR_SAVE1:  v = m_save[1];
          csr_pkg::CSR_SAVE2:  v = m_save[2];
          csr_pkg::CSR_SAVE3:  v = m_save[3];
          csr_pkg::CSR_TID:    v = m_tid;
          csr_pkg::CSR_TCFG:   v = m_tcfg;
          csr_pkg::CSR_TVAL:   v = m_tval;
          default:             v = '0;
        endcase
      end
    endcase
    return v;
  endfunction

  always @(posedge clk) begin : model_update
    logic        wr_en;
    logic        tcfg_wr;
    logic        expire;
    logic [31:0] merged;
    logic [31:0] rd_next;
    logic [31:0] crmd_old;
    logic [31:0] prmd_old;
    if (!rst_n) begin
      // only DA set after reset
      m_crmd   = 32'h0000_0008;
      m_prmd   = '0;
      m_era    = '0;
      m_eentry = '0;
      m_tcfg   = '0;
      m_tval   = '0;
      m_tid    = '0;
      m_rd     = '0;
      m_swi    = '0;
      m_hwi    = '0;
      m_ecode  = '0;
      m_esub   = '0;
      m_ten    = 1'b0;
      m_ti     = 1'b0;
      m_cnt    = '0;
      for (int k = 0; k < 4; k++) begin
        m_save[k] = '0;
      end
      model_valid = 1'b1;
    end else begin
      wr_en    = csr_we_i && valid_i && commit_i && !m2_stall_i;
      merged   = (m_rd & ~csr_w_mask_i) | (csr_w_data_i & csr_w_mask_i);
      rd_next  = read_model(csr_r_addr_i, rdcnt_i);
      crmd_old = m_crmd;
      prmd_old = m_prmd;
      tcfg_wr  = wr_en && (csr_w_addr_i == csr_pkg::CSR_TCFG);
      expire   = m_ten && (m_tval == 32'd0) && !tcfg_wr;
      m_hwi    = hw_int_i;
      // ie/plv sit at [2:0] in both crmd and prmd
      if (excp_i.excp) begin
        m_prmd[2:0] = crmd_old[2:0];
        m_crmd[2:0] = 3'b000;
        m_ecode     = excp_i.ecode;
        m_esub      = excp_i.esubcode;
        m_era       = excp_i.pc;
      end
      if (excp_i.ertn) begin
        m_crmd[2:0] = prmd_old[2:0];
      end
      if (wr_en) begin
        case (csr_w_addr_i)
          csr_pkg::CSR_CRMD:   m_crmd[8:0] = merged[8:0];
          csr_pkg::CSR_PRMD:   m_prmd[2:0] = merged[2:0];
          csr_pkg::CSR_ESTAT:  m_swi = merged[1:0];
          csr_pkg::CSR_ERA:    m_era = merged;
          csr_pkg::CSR_EENTRY: m_eentry = {merged[31:6], 6'b000000};
          csr_pkg::CSR_SAVE0:  m_save[0] = merged;
          csr_pkg::CSR_SAVE1:  m_save[1] = merged;
          csr_pkg::CSR_SAVE2:  m_save[2] = merged;
          csr_pkg::CSR_SAVE3:  m_save[3] = merged;
          csr_pkg::CSR_TID:    m_tid = merged;
          default:             ;
        endcase
      end
      if (tcfg_wr) begin
        m_tcfg = merged;
        m_tval = {merged[31:2], 2'b00};
        m_ten  = merged[0];
      end else if (m_ten) begin
        if (m_tval != 32'd0) begin
          m_tval = m_tval - 32'd1;
        end else begin
          m_tval = m_tcfg[1] ? {m_tcfg[31:2], 2'b00} : 32'hffff_ffff;
          m_ten  = m_tcfg[1];
        end
      end
      if (wr_en && (csr_w_addr_i == csr_pkg::CSR_TICLR) && merged[0]) begin
        m_ti = 1'b0;
      end else if (expire) begin
        m_ti = 1'b1;
      end
      m_cnt = m_cnt + 64'd1;
      if (!m2_stall_i) begin
        m_rd = rd_next;
      end
    end
  end

  task automatic check_word(input string what, input logic [31:0] got, input logic [31:0] exp);
    check_cnt_o++;
    if (got !== exp) begin
      err_cnt_o++;
      $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // outputs only move on the rising edge
  always @(negedge clk) begin
    if (model_valid) begin
      check_word("read data", r_data_i, m_rd);
      check_word("CRMD", state_i.crmd, m_crmd);
      check_word("PRMD", state_i.prmd, m_prmd);
      check_word("ESTAT", state_i.estat, estat_word());
      check_word("ERA", state_i.era, m_era);
      check_word("EENTRY", state_i.eentry, m_eentry);
    end
  end

endmodule

//--- testbench/csr_tb.sv
module csr_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_OPS        = 2000;
  localparam int RESET_CYCLES = 3;
  // one cycle per op, a quarter on top covers reset and drain
  localparam int CYCLE_LIMIT  = N_OPS + N_OPS / 4;

  logic                           clk = 1'b0;
  logic                           rst_n;
  logic                           csr_we_i;
  logic                           valid_i;
  logic                           commit_i;
  logic                           m2_stall_i;
  logic [csr_pkg::CSR_ADDR_W-1:0] csr_w_addr_i;
  logic [csr_pkg::XLEN-1:0]       csr_w_mask_i;
  logic [csr_pkg::XLEN-1:0]       csr_w_data_i;
  logic [csr_pkg::CSR_ADDR_W-1:0] csr_r_addr_i;
  logic [1:0]                     rdcnt_i;
  csr_pkg::excp_t                 excp_i;
  logic [7:0]                     hw_int_i;
  logic [csr_pkg::XLEN-1:0]       csr_r_data_o;
  csr_pkg::csr_state_t            csr_state_o;
  int                             err_cnt;
  int                             check_cnt;
  int                             cycle_cnt = 0;
  integer                         seed = 32'hf7d1e59a;
  int                             cur_kind;
  int                             next_kind;
  logic [13:0]                    cur_addr;
  logic [13:0]                    next_addr;

  always #20 clk = ~clk;

  csr_top csr_top_i (.*);

  csr_checker csr_checker_i (
    .clk (clk), .rst_n (rst_n), .csr_we_i (csr_we_i), .valid_i (valid_i),
    .commit_i (commit_i), .m2_stall_i (m2_stall_i), .csr_w_addr_i (csr_w_addr_i),
    .csr_w_mask_i (csr_w_mask_i), .csr_w_data_i (csr_w_data_i),
    .csr_r_addr_i (csr_r_addr_i), .rdcnt_i (rdcnt_i), .excp_i (excp_i),
    .hw_int_i (hw_int_i), .r_data_i (csr_r_data_o), .state_i (csr_state_o),
    .err_cnt_o (err_cnt), .check_cnt_o (check_cnt)
  );

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  function automatic logic [13:0] kept_addr(input int idx);
    case (idx)
      0:       return csr_pkg::CSR_CRMD;
      1:       return csr_pkg::CSR_PRMD;
      2:       return csr_pkg::CSR_ESTAT;
      3:       return csr_pkg::CSR_ERA;
      4:       return csr_pkg::CSR_EENTRY;
      5:       return csr_pkg::CSR_SAVE0;
      6:       return csr_pkg::CSR_SAVE1;
      7:       return csr_pkg::CSR_SAVE2;
      8:       return csr_pkg::CSR_SAVE3;
      9:       return csr_pkg::CSR_TID;
      10:      return csr_pkg::CSR_TCFG;
      11:      return csr_pkg::CSR_TVAL;
      default: return csr_pkg::CSR_TICLR;
    endcase
  endfunction

  task automatic drive_idle();
    csr_we_i     = 1'b0;
    valid_i      = 1'b1;
    commit_i     = 1'b1;
    m2_stall_i   = 1'b0;
    csr_w_addr_i = '0;
    csr_w_mask_i = '0;
    csr_w_data_i = '0;
    csr_r_addr_i = '0;
    rdcnt_i      = csr_pkg::RDCNT_NONE;
    excp_i       = '0;
  endtask

  // kinds 0-5 write, 6-7 blocked write, 8-9 stall, 10 excp, 11 ertn, else read
  task automatic pick_next_op();
    logic [31:0] r;
    r         = rand_word();
    next_kind = r[3:0];
    next_addr = kept_addr(r[11:8] % 13);
  endtask

  task automatic drive_op(input int kind, input logic [13:0] waddr, input bit pre_read,
                          input logic [13:0] raddr);
    logic [31:0] r;
    drive_idle();
    r        = rand_word();
    hw_int_i = r[7:0];
    // excp and ertn sometimes share their cycle with a write
    if (kind < 8 || (kind >= 10 && kind < 12 && r[23])) begin
      csr_we_i     = 1'b1;
      csr_w_addr_i = waddr;
      csr_w_data_i = rand_word();
      csr_w_mask_i = (r[9:8] == 2'd0) ? 32'hffff_ffff : rand_word();
      if (waddr == csr_pkg::CSR_TCFG) begin
        // short countdowns so the timer expires often
        csr_w_data_i = csr_w_data_i & 32'h0000_001f;
        if (r[11:10] != 2'd0) begin
          csr_w_mask_i = 32'hffff_ffff;
        end
      end
      if (kind == 6 || kind == 7) begin
        case (r[13:12])
          2'd0:    valid_i = 1'b0;
          2'd1:    commit_i = 1'b0;
          default: m2_stall_i = 1'b1;
        endcase
      end
    end
    if (kind == 8 || kind == 9) begin
      m2_stall_i = 1'b1;
    end else if (kind == 10) begin
      excp_i.excp     = 1'b1;
      excp_i.ecode    = r[13:8];
      excp_i.esubcode = r[22:14];
      excp_i.pc       = rand_word();
    end else if (kind == 11) begin
      excp_i.ertn = 1'b1;
    end
    // the merge uses read data for the same address one cycle earlier
    r = rand_word();
    if (pre_read) begin
      csr_r_addr_i = raddr;
    end else begin
      csr_r_addr_i = (r[2:0] == 3'd0) ? r[21:8] : kept_addr(r[7:4] % 13);
      rdcnt_i      = (r[25:24] == 2'd0) ? r[27:26] : csr_pkg::RDCNT_NONE;
    end
  endtask

  initial begin
    rst_n    = 1'b0;
    hw_int_i = '0;
    drive_idle();
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    pick_next_op();
    for (int i = 0; i < N_OPS; i++) begin
      cur_kind = next_kind;
      cur_addr = next_addr;
      pick_next_op();
      drive_op(cur_kind, cur_addr, (next_kind < 8) && (i < N_OPS - 1), next_addr);
      @(negedge clk);
    end
    drive_idle();
    repeat (2) @(negedge clk);
    @(posedge clk);
    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0 && check_cnt > 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

//--- project.f
source/csr_pkg.sv
source/csr_write_port.sv
source/csr_trap_regs.sv
source/csr_timer.sv
source/csr_save_regs.sv
source/csr_read_mux.sv
source/csr_top.sv
testbench/csr_checker.sv
testbench/csr_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the csr testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module csr_tb -f project.f
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

sim_out=$(./obj_dir/Vcsr_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with an error"
  exit 1
fi

if echo "$sim_out" | grep -qx "All tests passed"; then
  exit 0
fi
exit 1
